//--- include/pkt_defines.svh
// Byte link constants
`ifndef PKT_DEFINES_SVH
`define PKT_DEFINES_SVH

// Special characters of the byte stream.
`define PKT_SOP_CHAR     8'h7a  // Start of packet.
`define PKT_EOP_CHAR     8'h7b  // End of packet.
`define PKT_CHANNEL_CHAR 8'h7c  // Channel byte follows.
`define PKT_ESC_CHAR     8'h7d  // Next byte is escaped.

// Escaped bytes travel with this bit flipped.
`define PKT_ESC_XOR      8'h20

// Beat buffer in front of the encoder.
`define PKT_BEAT_DEPTH   4

// Link buffer between encoder and decoder.
// Holds up to this many bytes in flight.
`define PKT_LINK_DEPTH   8

`endif

//--- src/pkt_pkg.sv
// Packet link types
package pkt_pkg;

   // One packet beat as seen at either end of the link.
   typedef struct packed {
      logic [7:0] data;     // Payload byte.
      logic [7:0] channel;  // Channel number.
      logic       sop;      // First beat of a packet.
      logic       eop;      // Last beat of a packet.
   } pkt_beat_t;

   // Decoder position within the escaped byte stream.
   typedef enum logic [1:0] {
      normal,           // Expecting marker or data.
      escaped,          // Data byte follows, XORed.
      channel_next,     // Channel value follows.
      channel_escaped   // Channel value follows, XORed.
   } dec_state_t;

endpackage

//--- src/pkt_stream_if.sv
// Packet beat stream interface
`timescale 1ns/1ps

interface pkt_stream_if ();
   import pkt_pkg::*;

   logic      valid;  // Beat on the bus.
   logic      ready;  // Sink can take it.
   pkt_beat_t beat;   // Held stable until taken.

   // Side that produces beats.
   modport source (
      output valid,
      output beat,
      input  ready
   );

   // Side that consumes beats.
   modport sink (
      input  valid,
      input  beat,
      output ready
   );

endinterface

//--- src/stream_buffer.sv
// First-word-fall-through buffer
`timescale 1ns/1ps

module stream_buffer #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     reset_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_payload,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_payload
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

   payload_t         mem [DEPTH];  // Circular store.
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;        // Entries held.
   logic             push;
   logic             pop;

   // Pointers wrap on their own only for power-of-two depths.
   if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
      $error("stream_buffer DEPTH must be a power of two, at least 2");
   end

   assign in_ready    = (count != FULL_COUNT);
   assign out_valid   = (count != '0);  // Written entries show up a cycle later.
   assign out_payload = mem[rd_ptr];
   assign push        = in_valid & in_ready;
   assign pop         = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_payload;
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + PTR_W'(1);
         if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
         case ({push, pop})
            2'b10:   count <= count + (PTR_W + 1)'(1);
            2'b01:   count <= count - (PTR_W + 1)'(1);
            default: count <= count;  // Idle, or read and write together.
         endcase
      end
   end

endmodule

//--- src/packets_to_bytes.sv
// Packet to byte stream encoder
`timescale 1ns/1ps
`include "pkt_defines.svh"

module packets_to_bytes (
   input  logic       clk,
   input  logic       reset_n,
   pkt_stream_if.sink beat_in,
   output logic       out_valid,
   input  logic       out_ready,
   output logic [7:0] out_data
);

   // Steps already done for the beat at the input.
   logic       sent_chan_char;
   logic       sent_chan_esc;
   logic       sent_channel;
   logic       sent_sop;
   logic       sent_eop;
   logic       sent_esc;
   logic [8:0] stored_channel;  // All ones until the first header.

   logic       load;            // Output register takes a byte.
   logic       need_channel;
   logic       chan_needs_esc;
   logic       data_needs_esc;
   logic       beat_done;
   logic [7:0] next_byte;

   function automatic logic is_special(input logic [7:0] b);
      return b inside {`PKT_SOP_CHAR, `PKT_EOP_CHAR, `PKT_CHANNEL_CHAR, `PKT_ESC_CHAR};
   endfunction

   assign need_channel   = beat_in.beat.sop |
                           ({1'b0, beat_in.beat.channel} != stored_channel);
   assign chan_needs_esc = is_special(beat_in.beat.channel);
   assign data_needs_esc = is_special(beat_in.beat.data);

   // Only the data byte remains for this beat.
   assign beat_done = (~need_channel | sent_channel) &
                      (~beat_in.beat.sop | sent_sop) &
                      (~beat_in.beat.eop | sent_eop) &
                      (~data_needs_esc | sent_esc);

   assign load          = beat_in.valid & (out_ready | ~out_valid);
   assign beat_in.ready = load & beat_done;  // Consumed with its data byte.

   // Channel header, SOP, EOP, escape, then data.
   always_comb begin
      if (need_channel && !sent_channel) begin
         if (!sent_chan_char)                     next_byte = `PKT_CHANNEL_CHAR;
         else if (chan_needs_esc && !sent_chan_esc) next_byte = `PKT_ESC_CHAR;
         else if (chan_needs_esc)                 next_byte = beat_in.beat.channel ^ `PKT_ESC_XOR;
         else                                     next_byte = beat_in.beat.channel;
      end else if (beat_in.beat.sop && !sent_sop) begin
         next_byte = `PKT_SOP_CHAR;
      end else if (beat_in.beat.eop && !sent_eop) begin
         next_byte = `PKT_EOP_CHAR;
      end else if (data_needs_esc && !sent_esc) begin
         next_byte = `PKT_ESC_CHAR;
      end else begin
         next_byte = sent_esc ? (beat_in.beat.data ^ `PKT_ESC_XOR) : beat_in.beat.data;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         out_valid      <= 1'b0;
         sent_chan_char <= 1'b0;
         sent_chan_esc  <= 1'b0;
         sent_channel   <= 1'b0;
         sent_sop       <= 1'b0;
         sent_eop       <= 1'b0;
         sent_esc       <= 1'b0;
      end else begin
         if (load) out_valid <= 1'b1;
         else if (out_ready) out_valid <= 1'b0;

         if (load) begin
            if (need_channel && !sent_channel) begin
               if (!sent_chan_char) sent_chan_char <= 1'b1;
               else if (chan_needs_esc && !sent_chan_esc) sent_chan_esc <= 1'b1;
               else sent_channel <= 1'b1;
            end else if (beat_in.beat.sop && !sent_sop) begin
               sent_sop <= 1'b1;
            end else if (beat_in.beat.eop && !sent_eop) begin
               sent_eop <= 1'b1;
            end else if (data_needs_esc && !sent_esc) begin
               sent_esc <= 1'b1;
            end else begin  // Data byte out, start over for the next beat.
               sent_chan_char <= 1'b0;
               sent_chan_esc  <= 1'b0;
               sent_channel   <= 1'b0;
               sent_sop       <= 1'b0;
               sent_eop       <= 1'b0;
               sent_esc       <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) out_data <= next_byte;
   end

   // Remember the channel once its value byte is out.
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) stored_channel <= '1;
      else if (sent_channel) stored_channel <= {1'b0, beat_in.beat.channel};
   end

endmodule

//--- src/bytes_to_packets.sv
// Byte stream to packet decoder
`timescale 1ns/1ps
`include "pkt_defines.svh"

module bytes_to_packets (
   input  logic         clk,
   input  logic         reset_n,
   input  logic         in_valid,
   output logic         in_ready,
   input  logic [7:0]   in_data,
   pkt_stream_if.source beat_out
);
   import pkt_pkg::*;

   dec_state_t state;
   logic       pend_sop;   // SOP marker seen, no data yet.
   logic       pend_eop;   // EOP marker seen, no data yet.
   logic [7:0] channel;    // Channel of the next data byte.
   logic       take;       // Byte consumed this cycle.
   logic       emit;       // Consumed byte is data.
   logic [7:0] emit_data;
   logic       valid_q;
   pkt_beat_t  beat_q;

   assign in_ready       = beat_out.ready | ~valid_q;
   assign take           = in_valid & in_ready;
   assign beat_out.valid = valid_q;
   assign beat_out.beat  = beat_q;

   // Which bytes carry data, and their restored value.
   always_comb begin
      emit      = 1'b0;
      emit_data = in_data;
      case (state)
         normal: begin
            case (in_data)
               `PKT_SOP_CHAR, `PKT_EOP_CHAR, `PKT_CHANNEL_CHAR, `PKT_ESC_CHAR: emit = 1'b0;
               default: emit = 1'b1;
            endcase
         end
         escaped: begin
            emit      = 1'b1;
            emit_data = in_data ^ `PKT_ESC_XOR;
         end
         default: emit = 1'b0;  // Channel bytes.
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state    <= normal;
         pend_sop <= 1'b0;
         pend_eop <= 1'b0;
         channel  <= '0;
      end else if (take) begin
         case (state)
            normal: begin
               case (in_data)
                  `PKT_SOP_CHAR:     pend_sop <= 1'b1;
                  `PKT_EOP_CHAR:     pend_eop <= 1'b1;
                  `PKT_CHANNEL_CHAR: state <= channel_next;
                  `PKT_ESC_CHAR:     state <= escaped;
                  default:           state <= normal;
               endcase
            end
            escaped: state <= normal;
            channel_next: begin
               if (in_data == `PKT_ESC_CHAR) begin
                  state <= channel_escaped;
               end else begin
                  channel <= in_data;
                  state   <= normal;
               end
            end
            channel_escaped: begin
               channel <= in_data ^ `PKT_ESC_XOR;
               state   <= normal;
            end
            default: state <= normal;
         endcase

         // Flags belong to the beat just emitted.
         if (emit) begin
            pend_sop <= 1'b0;
            pend_eop <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) valid_q <= 1'b0;
      else if (take && emit) valid_q <= 1'b1;
      else if (beat_out.ready) valid_q <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (take && emit) begin
         beat_q.data    <= emit_data;
         beat_q.channel <= channel;
         beat_q.sop     <= pend_sop;
         beat_q.eop     <= pend_eop;
      end
   end

endmodule

//--- src/pkt_link_top.sv
// Packet link loopback top
`timescale 1ns/1ps
`include "pkt_defines.svh"

module pkt_link_top (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       in_valid,
   output logic       in_ready,
   input  logic [7:0] in_data,
   input  logic [7:0] in_channel,
   input  logic       in_startofpacket,
   input  logic       in_endofpacket,
   output logic       out_valid,
   input  logic       out_ready,
   output logic [7:0] out_data,
   output logic [7:0] out_channel,
   output logic       out_startofpacket,
   output logic       out_endofpacket
);
   import pkt_pkg::*;

   pkt_beat_t  in_beat;
   logic       enc_valid;   // Encoder to link buffer.
   logic       enc_ready;
   logic [7:0] enc_data;
   logic       link_valid;  // Link buffer to decoder.
   logic       link_ready;
   logic [7:0] link_data;

   pkt_stream_if beat_if ();
   pkt_stream_if dec_if ();

   assign in_beat = '{data: in_data, channel: in_channel,
                      sop: in_startofpacket, eop: in_endofpacket};

   stream_buffer #(.payload_t(pkt_beat_t), .DEPTH(`PKT_BEAT_DEPTH)) u_beat_buffer (
      .clk, .reset_n,
      .in_valid,
      .in_ready,
      .in_payload  (in_beat),
      .out_valid   (beat_if.valid),
      .out_ready   (beat_if.ready),
      .out_payload (beat_if.beat)
   );

   packets_to_bytes u_encoder (
      .clk, .reset_n,
      .beat_in   (beat_if),
      .out_valid (enc_valid),
      .out_ready (enc_ready),
      .out_data  (enc_data)
   );

   // Stands in for the physical byte link.
   stream_buffer #(.payload_t(logic [7:0]), .DEPTH(`PKT_LINK_DEPTH)) u_link_buffer (
      .clk, .reset_n,
      .in_valid    (enc_valid),
      .in_ready    (enc_ready),
      .in_payload  (enc_data),
      .out_valid   (link_valid),
      .out_ready   (link_ready),
      .out_payload (link_data)
   );

   bytes_to_packets u_decoder (
      .clk, .reset_n,
      .in_valid (link_valid),
      .in_ready (link_ready),
      .in_data  (link_data),
      .beat_out (dec_if)
   );

   assign out_valid         = dec_if.valid;
   assign dec_if.ready      = out_ready;
   assign out_data          = dec_if.beat.data;
   assign out_channel       = dec_if.beat.channel;
   assign out_startofpacket = dec_if.beat.sop;
   assign out_endofpacket   = dec_if.beat.eop;

endmodule

//--- tests/pkt_link_properties.sv
// Encoder byte output checks
`timescale 1ns/1ps
`include "pkt_defines.svh"

module pkt_link_properties (
   input logic       clk,
   input logic       reset_n,
   input logic       out_valid,
   input logic       out_ready,
   input logic [7:0] out_data
);

   int   error_count = 0;  // Read by the testbench.
   logic after_esc;        // Last byte taken was an escape.
   logic data_special;

   assign data_special = out_data inside {`PKT_SOP_CHAR, `PKT_EOP_CHAR,
                                          `PKT_CHANNEL_CHAR, `PKT_ESC_CHAR};

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) after_esc <= 1'b0;
      else if (out_valid && out_ready) after_esc <= (out_data == `PKT_ESC_CHAR);
   end

   // A stalled byte stays on the bus unchanged.
   a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
   else begin
      $error("Encoder byte changed or dropped while the link was stalled");
      error_count++;
   end

   a_escaped_byte: assert property (@(posedge clk) disable iff (!reset_n)
      out_valid && out_ready && after_esc |-> !data_special)
   else begin
      $error("Encoder sent a raw special character right after an escape");
      error_count++;
   end

   a_reset_idle: assert property (@(posedge clk) $rose(reset_n) |-> !out_valid)
   else begin
      $error("Encoder output valid high in the cycle after reset release");
      error_count++;
   end

endmodule

bind packets_to_bytes pkt_link_properties u_props (
   .clk, .reset_n, .out_valid, .out_ready, .out_data
);

//--- tests/pkt_link_tb.sv
// Packet link loopback testbench
`timescale 1ns/1ps

module pkt_link_tb;
   import pkt_pkg::*;

   // Data bytes per test with the random test at its upper bound.
   localparam int TOTAL_BYTES = 2 + 15 + 8 + 12 + 120;
   localparam int CYCLE_LIMIT = 40 * TOTAL_BYTES + 2000;

   logic       clk = 1'b0;
   logic       reset_n;
   logic       in_valid;
   logic       in_ready;
   logic [7:0] in_data;
   logic [7:0] in_channel;
   logic       in_startofpacket;
   logic       in_endofpacket;
   logic       out_valid;
   logic       out_ready;
   logic [7:0] out_data;
   logic [7:0] out_channel;
   logic       out_startofpacket;
   logic       out_endofpacket;

   pkt_beat_t  expect_q[$];  // Accepted input beats in order.
   string      test_name;
   int         errors = 0;
   int         checked = 0;
   int         tests = 0;
   int         cycles = 0;
   int         base_errors;
   int         base_checked;
   bit         random_ready;
   bit         random_gaps;
   bit         enc_seen;
   logic [7:0] first_enc_byte;

   pkt_link_top u_dut (.*);

   always #4 clk = ~clk;

   function automatic string beat_str(input pkt_beat_t b);
      return $sformatf("data %h ch %h sop %b eop %b", b.data, b.channel, b.sop, b.eop);
   endfunction

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout in %s: output stalled with %0d beats still expected",
                  test_name, expect_q.size());
         $display("RESULT: FAIL");
         $finish;
      end
   end

   always @(posedge clk) begin
      #1;
      out_ready = random_ready ? ($urandom_range(0, 9) < 3) : 1'b1;  // About 30 percent.
   end

   // First byte on the link after reset.
   always @(posedge clk) begin
      if (reset_n && !enc_seen && u_dut.enc_valid && u_dut.enc_ready) begin
         first_enc_byte <= u_dut.enc_data;
         enc_seen       <= 1'b1;
      end
   end

   always @(posedge clk) begin
      pkt_beat_t got;
      pkt_beat_t want;
      if (reset_n && out_valid && out_ready) begin
         got = '{data: out_data, channel: out_channel,
                 sop: out_startofpacket, eop: out_endofpacket};
         assert (expect_q.size() > 0)
         else begin
            $display("Error in %s: output beat %s arrived with no input beat left",
                     test_name, beat_str(got));
            errors++;
         end
         if (expect_q.size() > 0) begin
            want = expect_q.pop_front();
            checked++;
            assert (got == want)
            else begin
               $display("Fail %s: expected %s, actual %s", test_name, beat_str(want),
                        beat_str(got));
               errors++;
            end
         end
      end
   end

   // Entered and left 1 ns after a rising edge.
   task automatic send_beat(input logic [7:0] data, input logic [7:0] channel,
                            input logic sop, input logic eop);
      int gap;
      gap = random_gaps ? $urandom_range(0, 3) : 0;
      repeat (gap) begin
         @(posedge clk);
         #1;
      end
      in_valid         = 1'b1;
      in_data          = data;
      in_channel       = channel;
      in_startofpacket = sop;
      in_endofpacket   = eop;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      expect_q.push_back('{data: data, channel: channel, sop: sop, eop: eop});
      #1;
      in_valid = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name    = name;
      base_errors  = errors;
      base_checked = checked;
      tests++;
   endtask

   task automatic wait_drain();
      while (expect_q.size() != 0) @(posedge clk);
      #1;
   endtask

   task automatic finish_test();
      wait_drain();
      $display("Test %s done: %0d beats checked, %0d errors", test_name,
               checked - base_checked, errors - base_errors);
   endtask

   initial begin
      logic [7:0] chan;
      int         len;
      void'($urandom(32'h3d5c));
      reset_n          = 1'b0;
      in_valid         = 1'b0;
      in_data          = '0;
      in_channel       = '0;
      in_startofpacket = 1'b0;
      in_endofpacket   = 1'b0;
      out_ready        = 1'b1;
      random_ready     = 1'b0;
      random_gaps      = 1'b0;
      enc_seen         = 1'b0;
      repeat (10) @(posedge clk);
      #1 reset_n = 1'b1;

      start_test("reset");
      @(posedge clk);
      #1;
      assert (!out_valid && !u_dut.u_encoder.out_valid)
      else begin
         $display("Error in reset: a valid output is high after reset");
         errors++;
      end
      send_beat(8'h11, 8'h00, 1'b0, 1'b0);  // Without SOP only the reset value forces a header.
      send_beat(8'h22, 8'h00, 1'b0, 1'b1);
      wait_drain();
      assert (enc_seen && first_enc_byte == 8'h7c)
      else begin
         $display("Fail %s: expected first link byte 7c, actual %h", test_name,
                  first_enc_byte);
         errors++;
      end
      finish_test();

      start_test("plain");
      for (int p = 0; p < 3; p++) begin
         for (int i = 0; i < 5; i++)
            send_beat(8'(p * 16 + i), 8'(p % 2 + 1), i == 0, i == 4);
      end
      finish_test();

      start_test("escape");
      for (int i = 0; i < 4; i++)
         send_beat(8'h7a + 8'(i), 8'h02, 1'b1, 1'b1);
      for (int i = 0; i < 4; i++)
         send_beat(8'h7d - 8'(i), 8'h02, i == 0, i == 3);
      finish_test();

      start_test("channels");
      for (int i = 0; i < 4; i++)
         send_beat(8'h30 + 8'(i), (i < 2) ? 8'h03 : 8'h09, i == 0, i == 3);
      for (int i = 0; i < 4; i++)
         send_beat(8'h7a + 8'(i), 8'h7a + 8'(i), i == 0, i == 3);  // Switches every beat.
      for (int i = 0; i < 4; i++)
         send_beat(8'h40 + 8'(i), 8'h7d - 8'(i), 1'b1, 1'b1);
      finish_test();

      start_test("backpressure");
      random_ready = 1'b1;
      random_gaps  = 1'b1;
      for (int p = 0; p < 20; p++) begin
         len = $urandom_range(1, 6);
         for (int i = 0; i < len; i++) begin
            if (i == 0 || $urandom_range(0, 3) == 0)
               chan = $urandom_range(0, 1) ? 8'h7a + 8'($urandom_range(0, 3))
                                           : 8'($urandom_range(0, 3));
            send_beat(($urandom_range(0, 4) == 0) ? 8'h7a + 8'($urandom_range(0, 3))
                                                  : 8'($urandom_range(0, 255)),
                      chan, i == 0, i == len - 1);
         end
      end
      finish_test();
      random_ready = 1'b0;
      random_gaps  = 1'b0;

      errors += u_dut.u_encoder.u_props.error_count;
      $display("Tests: %0d, beats checked: %0d, errors: %0d", tests, checked, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+include
src/pkt_pkg.sv
src/pkt_stream_if.sv
src/stream_buffer.sv
src/packets_to_bytes.sv
src/bytes_to_packets.sv
src/pkt_link_top.sv
tests/pkt_link_properties.sv
tests/pkt_link_tb.sv

//--- Bender.yml
package:
  name: pkt_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/pkt_pkg.sv
      - src/pkt_stream_if.sv
      - src/stream_buffer.sv
      - src/packets_to_bytes.sv
      - src/bytes_to_packets.sv
      - src/pkt_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/pkt_link_properties.sv
      - tests/pkt_link_tb.sv
